// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --timescale 1ns/1ps
TOP       := tb_wb_copperv_bus
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_TEXT := *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output.
sim: build
	./$(OBJ_DIR)/V$(TOP) | awk -v pass='$(PASS_TEXT)' \
		'{ print } $$0 == pass { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/copperv_bus_defs.svh ====
`ifndef COPPERV_BUS_DEFS_SVH
`define COPPERV_BUS_DEFS_SVH

// widths of the core channels and the shared wishbone port.
`define COPPERV_ADDR_WIDTH   32
`define COPPERV_DATA_WIDTH   32

// one byte enable per data byte.
`define COPPERV_STROBE_WIDTH (`COPPERV_DATA_WIDTH / 8)

// data write, data read and instruction read.
`define COPPERV_MASTERS      3

`endif

// ==== logic/copperv_bus_pkg.sv ====
`default_nettype none

package copperv_bus_pkg;

    // response of the data write channel.
    typedef enum logic {
        RESP_OK  = 1'b0,
        RESP_ERR = 1'b1
    } bus_resp_t;

    // read adapter.
    typedef enum logic [1:0] {
        RD_IDLE = 2'd0,
        RD_BUS  = 2'd1,
        RD_DATA = 2'd2
    } rd_state_t;

    // write adapter.
    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_BUS  = 2'd1,
        WR_RESP = 2'd2
    } wr_state_t;

endpackage

`default_nettype wire

// ==== logic/wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "copperv_bus_defs.svh"

module wb_arbiter #(
    parameter int p_masters = `COPPERV_MASTERS
) (
    input  wire                                             i_clock,
    input  wire                                             i_rst_n,
    input  wire  [p_masters-1:0][`COPPERV_ADDR_WIDTH-1:0]   i_m_adr,
    input  wire  [p_masters-1:0][`COPPERV_DATA_WIDTH-1:0]   i_m_datwr,
    input  wire  [p_masters-1:0]                            i_m_we,
    input  wire  [p_masters-1:0]                            i_m_stb,
    input  wire  [p_masters-1:0]                            i_m_cyc,
    input  wire  [p_masters-1:0][`COPPERV_STROBE_WIDTH-1:0] i_m_sel,
    output logic [p_masters-1:0]                            o_m_ack,
    output logic [p_masters-1:0]                            o_m_err,
    output logic [`COPPERV_ADDR_WIDTH-1:0]                  o_wb_adr,
    output logic [`COPPERV_DATA_WIDTH-1:0]                  o_wb_datwr,
    output logic                                            o_wb_we,
    output logic                                            o_wb_stb,
    output logic                                            o_wb_cyc,
    output logic [`COPPERV_STROBE_WIDTH-1:0]                o_wb_sel,
    input  wire                                             i_wb_ack,
    input  wire                                             i_wb_err
);

    localparam int c_idx_width = $clog2(p_masters);

    logic                   busy_q;
    logic [c_idx_width-1:0] owner_q;
    logic                   owner_active;
    logic [c_idx_width-1:0] pick;
    logic                   pick_valid;
    logic [c_idx_width-1:0] grant;
    logic                   grant_valid;

    // lowest index wins, so scan from the top and let later hits overwrite.
    always_comb begin
        pick       = '0;
        pick_valid = 1'b0;
        for (int m = p_masters - 1; m >= 0; m--) begin
            if (i_m_cyc[m]) begin
                pick       = c_idx_width'(m);
                pick_valid = 1'b1;
            end
        end
    end

    // the owner holds the port until it drops cyc.
    assign owner_active = busy_q && i_m_cyc[owner_q];
    assign grant        = owner_active ? owner_q : pick;
    assign grant_valid  = owner_active || pick_valid;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q  <= 1'b0;
            owner_q <= '0;
        end else begin
            busy_q  <= grant_valid;
            owner_q <= grant;
        end
    end

    always_comb begin
        o_wb_adr   = '0;
        o_wb_datwr = '0;
        o_wb_we    = 1'b0;
        o_wb_stb   = 1'b0;
        o_wb_cyc   = 1'b0;
        o_wb_sel   = '0;
        if (grant_valid) begin
            o_wb_adr   = i_m_adr[grant];
            o_wb_datwr = i_m_datwr[grant];
            o_wb_we    = i_m_we[grant];
            o_wb_stb   = i_m_stb[grant];
            o_wb_cyc   = i_m_cyc[grant];
            o_wb_sel   = i_m_sel[grant];
        end
    end

    // masters that are not granted keep waiting with cyc high.
    always_comb begin
        for (int m = 0; m < p_masters; m++) begin
            o_m_ack[m] = grant_valid && (grant == c_idx_width'(m)) && i_wb_ack;
            o_m_err[m] = grant_valid && (grant == c_idx_width'(m)) && i_wb_err;
        end
    end

endmodule

`default_nettype wire

// ==== logic/wb_copperv_bus.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "copperv_bus_defs.svh"

module wb_copperv_bus (
    input  wire                              i_clock,
    input  wire                              i_rst_n,
    input  wire                              i_ir_addr_valid,
    output logic                             o_ir_addr_ready,
    input  wire  [`COPPERV_ADDR_WIDTH-1:0]   i_ir_addr,
    output logic                             o_ir_data_valid,
    input  wire                              i_ir_data_ready,
    output logic [`COPPERV_DATA_WIDTH-1:0]   o_ir_data,
    input  wire                              i_dr_addr_valid,
    output logic                             o_dr_addr_ready,
    input  wire  [`COPPERV_ADDR_WIDTH-1:0]   i_dr_addr,
    output logic                             o_dr_data_valid,
    input  wire                              i_dr_data_ready,
    output logic [`COPPERV_DATA_WIDTH-1:0]   o_dr_data,
    input  wire                              i_dw_data_addr_valid,
    output logic                             o_dw_data_addr_ready,
    input  wire  [`COPPERV_DATA_WIDTH-1:0]   i_dw_data,
    input  wire  [`COPPERV_ADDR_WIDTH-1:0]   i_dw_addr,
    input  wire  [`COPPERV_STROBE_WIDTH-1:0] i_dw_strobe,
    output logic                             o_dw_resp_valid,
    input  wire                              i_dw_resp_ready,
    output copperv_bus_pkg::bus_resp_t       o_dw_resp,
    output logic [`COPPERV_ADDR_WIDTH-1:0]   o_wb_adr,
    output logic [`COPPERV_DATA_WIDTH-1:0]   o_wb_datwr,
    input  wire  [`COPPERV_DATA_WIDTH-1:0]   i_wb_datrd,
    output logic                             o_wb_we,
    output logic                             o_wb_stb,
    input  wire                              i_wb_ack,
    input  wire                              i_wb_err,
    output logic                             o_wb_cyc,
    output logic [`COPPERV_STROBE_WIDTH-1:0] o_wb_sel
);

    logic [`COPPERV_ADDR_WIDTH-1:0]   dw_wb_adr;
    logic [`COPPERV_DATA_WIDTH-1:0]   dw_wb_datwr;
    logic                             dw_wb_we;
    logic                             dw_wb_stb;
    logic                             dw_wb_cyc;
    logic [`COPPERV_STROBE_WIDTH-1:0] dw_wb_sel;

    logic [`COPPERV_ADDR_WIDTH-1:0]   dr_wb_adr;
    logic                             dr_wb_stb;
    logic                             dr_wb_cyc;
    logic [`COPPERV_STROBE_WIDTH-1:0] dr_wb_sel;

    logic [`COPPERV_ADDR_WIDTH-1:0]   ir_wb_adr;
    logic                             ir_wb_stb;
    logic                             ir_wb_cyc;
    logic [`COPPERV_STROBE_WIDTH-1:0] ir_wb_sel;

    // read masters never write.
    logic [`COPPERV_DATA_WIDTH-1:0]   rd_wb_datwr;
    logic                             rd_wb_we;

    logic [`COPPERV_MASTERS-1:0]      m_ack;
    logic [`COPPERV_MASTERS-1:0]      m_err;

    assign rd_wb_datwr = '0;
    assign rd_wb_we    = 1'b0;

    wb_write_adapter u_dw_adapter (
        .i_clock           (i_clock),
        .i_rst_n           (i_rst_n),
        .i_data_addr_valid (i_dw_data_addr_valid),
        .o_data_addr_ready (o_dw_data_addr_ready),
        .i_data            (i_dw_data),
        .i_addr            (i_dw_addr),
        .i_strobe          (i_dw_strobe),
        .o_resp_valid      (o_dw_resp_valid),
        .i_resp_ready      (i_dw_resp_ready),
        .o_resp            (o_dw_resp),
        .o_wb_adr          (dw_wb_adr),
        .o_wb_datwr        (dw_wb_datwr),
        .o_wb_we           (dw_wb_we),
        .o_wb_stb          (dw_wb_stb),
        .o_wb_cyc          (dw_wb_cyc),
        .o_wb_sel          (dw_wb_sel),
        .i_wb_ack          (m_ack[0]),
        .i_wb_err          (m_err[0])
    );

    wb_read_adapter u_dr_adapter (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_addr_valid (i_dr_addr_valid),
        .o_addr_ready (o_dr_addr_ready),
        .i_addr       (i_dr_addr),
        .o_data_valid (o_dr_data_valid),
        .i_data_ready (i_dr_data_ready),
        .o_data       (o_dr_data),
        .o_wb_adr     (dr_wb_adr),
        .o_wb_stb     (dr_wb_stb),
        .o_wb_cyc     (dr_wb_cyc),
        .o_wb_sel     (dr_wb_sel),
        .i_wb_datrd   (i_wb_datrd),
        .i_wb_ack     (m_ack[1]),
        .i_wb_err     (m_err[1])
    );

    wb_read_adapter u_ir_adapter (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_addr_valid (i_ir_addr_valid),
        .o_addr_ready (o_ir_addr_ready),
        .i_addr       (i_ir_addr),
        .o_data_valid (o_ir_data_valid),
        .i_data_ready (i_ir_data_ready),
        .o_data       (o_ir_data),
        .o_wb_adr     (ir_wb_adr),
        .o_wb_stb     (ir_wb_stb),
        .o_wb_cyc     (ir_wb_cyc),
        .o_wb_sel     (ir_wb_sel),
        .i_wb_datrd   (i_wb_datrd),
        .i_wb_ack     (m_ack[2]),
        .i_wb_err     (m_err[2])
    );

    // index 0 is the data write and has the highest priority.
    wb_arbiter #(
        .p_masters (`COPPERV_MASTERS)
    ) u_arbiter (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_m_adr    ({ir_wb_adr, dr_wb_adr, dw_wb_adr}),
        .i_m_datwr  ({rd_wb_datwr, rd_wb_datwr, dw_wb_datwr}),
        .i_m_we     ({rd_wb_we, rd_wb_we, dw_wb_we}),
        .i_m_stb    ({ir_wb_stb, dr_wb_stb, dw_wb_stb}),
        .i_m_cyc    ({ir_wb_cyc, dr_wb_cyc, dw_wb_cyc}),
        .i_m_sel    ({ir_wb_sel, dr_wb_sel, dw_wb_sel}),
        .o_m_ack    (m_ack),
        .o_m_err    (m_err),
        .o_wb_adr   (o_wb_adr),
        .o_wb_datwr (o_wb_datwr),
        .o_wb_we    (o_wb_we),
        .o_wb_stb   (o_wb_stb),
        .o_wb_cyc   (o_wb_cyc),
        .o_wb_sel   (o_wb_sel),
        .i_wb_ack   (i_wb_ack),
        .i_wb_err   (i_wb_err)
    );

endmodule

`default_nettype wire

// ==== logic/wb_read_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "copperv_bus_defs.svh"

module wb_read_adapter (
    input  wire                              i_clock,
    input  wire                              i_rst_n,
    input  wire                              i_addr_valid,
    output logic                             o_addr_ready,
    input  wire  [`COPPERV_ADDR_WIDTH-1:0]   i_addr,
    output logic                             o_data_valid,
    input  wire                              i_data_ready,
    output logic [`COPPERV_DATA_WIDTH-1:0]   o_data,
    output logic [`COPPERV_ADDR_WIDTH-1:0]   o_wb_adr,
    output logic                             o_wb_stb,
    output logic                             o_wb_cyc,
    output logic [`COPPERV_STROBE_WIDTH-1:0] o_wb_sel,
    input  wire  [`COPPERV_DATA_WIDTH-1:0]   i_wb_datrd,
    input  wire                              i_wb_ack,
    input  wire                              i_wb_err
);

    copperv_bus_pkg::rd_state_t    state_q;
    copperv_bus_pkg::rd_state_t    state_d;
    logic [`COPPERV_ADDR_WIDTH-1:0] addr_q;
    logic [`COPPERV_DATA_WIDTH-1:0] data_q;
    logic                           bus_done;

    // an error ends the cycle just like an ack.
    assign bus_done = i_wb_ack || i_wb_err;

    always_comb begin
        state_d = state_q;
        case (state_q)
            copperv_bus_pkg::RD_IDLE: begin
                if (i_addr_valid) begin
                    state_d = copperv_bus_pkg::RD_BUS;
                end
            end
            copperv_bus_pkg::RD_BUS: begin
                if (bus_done) begin
                    state_d = copperv_bus_pkg::RD_DATA;
                end
            end
            copperv_bus_pkg::RD_DATA: begin
                if (i_data_ready) begin
                    state_d = copperv_bus_pkg::RD_IDLE;
                end
            end
            default: begin
                state_d = copperv_bus_pkg::RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= copperv_bus_pkg::RD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge i_clock) begin
        if (o_addr_ready && i_addr_valid) begin
            addr_q <= i_addr;
        end
        if (o_wb_cyc && bus_done) begin
            data_q <= i_wb_datrd;
        end
    end

    assign o_addr_ready = (state_q == copperv_bus_pkg::RD_IDLE);
    assign o_data_valid = (state_q == copperv_bus_pkg::RD_DATA);
    assign o_data       = data_q;

    // reads always fetch the whole word.
    assign o_wb_cyc = (state_q == copperv_bus_pkg::RD_BUS);
    assign o_wb_stb = o_wb_cyc;
    assign o_wb_adr = addr_q;
    assign o_wb_sel = {`COPPERV_STROBE_WIDTH{o_wb_cyc}};

endmodule

`default_nettype wire

// ==== logic/wb_write_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "copperv_bus_defs.svh"

module wb_write_adapter (
    input  wire                              i_clock,
    input  wire                              i_rst_n,
    input  wire                              i_data_addr_valid,
    output logic                             o_data_addr_ready,
    input  wire  [`COPPERV_DATA_WIDTH-1:0]   i_data,
    input  wire  [`COPPERV_ADDR_WIDTH-1:0]   i_addr,
    input  wire  [`COPPERV_STROBE_WIDTH-1:0] i_strobe,
    output logic                             o_resp_valid,
    input  wire                              i_resp_ready,
    output copperv_bus_pkg::bus_resp_t       o_resp,
    output logic [`COPPERV_ADDR_WIDTH-1:0]   o_wb_adr,
    output logic [`COPPERV_DATA_WIDTH-1:0]   o_wb_datwr,
    output logic                             o_wb_we,
    output logic                             o_wb_stb,
    output logic                             o_wb_cyc,
    output logic [`COPPERV_STROBE_WIDTH-1:0] o_wb_sel,
    input  wire                              i_wb_ack,
    input  wire                              i_wb_err
);

    copperv_bus_pkg::wr_state_t       state_q;
    copperv_bus_pkg::wr_state_t       state_d;
    copperv_bus_pkg::bus_resp_t       resp_q;
    logic [`COPPERV_ADDR_WIDTH-1:0]   addr_q;
    logic [`COPPERV_DATA_WIDTH-1:0]   data_q;
    logic [`COPPERV_STROBE_WIDTH-1:0] strobe_q;
    logic                             bus_done;

    assign bus_done = i_wb_ack || i_wb_err;

    always_comb begin
        state_d = state_q;
        case (state_q)
            copperv_bus_pkg::WR_IDLE: begin
                if (i_data_addr_valid) begin
                    state_d = copperv_bus_pkg::WR_BUS;
                end
            end
            copperv_bus_pkg::WR_BUS: begin
                if (bus_done) begin
                    state_d = copperv_bus_pkg::WR_RESP;
                end
            end
            copperv_bus_pkg::WR_RESP: begin
                if (i_resp_ready) begin
                    state_d = copperv_bus_pkg::WR_IDLE;
                end
            end
            default: begin
                state_d = copperv_bus_pkg::WR_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= copperv_bus_pkg::WR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge i_clock) begin
        if (o_data_addr_ready && i_data_addr_valid) begin
            addr_q   <= i_addr;
            data_q   <= i_data;
            strobe_q <= i_strobe;
        end
        // err takes precedence if a slave ever raises both.
        if (o_wb_cyc && bus_done) begin
            resp_q <= i_wb_err ? copperv_bus_pkg::RESP_ERR : copperv_bus_pkg::RESP_OK;
        end
    end

    assign o_data_addr_ready = (state_q == copperv_bus_pkg::WR_IDLE);
    assign o_resp_valid      = (state_q == copperv_bus_pkg::WR_RESP);
    assign o_resp            = resp_q;

    assign o_wb_cyc   = (state_q == copperv_bus_pkg::WR_BUS);
    assign o_wb_stb   = o_wb_cyc;
    assign o_wb_we    = o_wb_cyc;
    assign o_wb_adr   = addr_q;
    assign o_wb_datwr = data_q;
    assign o_wb_sel   = o_wb_cyc ? strobe_q : '0;

endmodule

`default_nettype wire

// ==== testbench/tb_wb_copperv_bus.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "copperv_bus_defs.svh"

module tb_wb_copperv_bus;

    localparam int c_words         = 256;
    localparam int c_timeout       = 50;
    localparam int c_ir_addr_ready = 0;
    localparam int c_ir_data_valid = 1;
    localparam int c_dr_addr_ready = 2;
    localparam int c_dr_data_valid = 3;
    localparam int c_dw_addr_ready = 4;
    localparam int c_dw_resp_valid = 5;

    logic                             clock = 1'b0;
    logic                             rst_n;
    logic                             i_ir_addr_valid;
    logic [`COPPERV_ADDR_WIDTH-1:0]   i_ir_addr;
    logic                             i_ir_data_ready;
    logic                             i_dr_addr_valid;
    logic [`COPPERV_ADDR_WIDTH-1:0]   i_dr_addr;
    logic                             i_dr_data_ready;
    logic                             i_dw_data_addr_valid;
    logic [`COPPERV_DATA_WIDTH-1:0]   i_dw_data;
    logic [`COPPERV_ADDR_WIDTH-1:0]   i_dw_addr;
    logic [`COPPERV_STROBE_WIDTH-1:0] i_dw_strobe;
    logic                             i_dw_resp_ready;
    logic                             o_ir_addr_ready;
    logic                             o_ir_data_valid;
    logic [`COPPERV_DATA_WIDTH-1:0]   o_ir_data;
    logic                             o_dr_addr_ready;
    logic                             o_dr_data_valid;
    logic [`COPPERV_DATA_WIDTH-1:0]   o_dr_data;
    logic                             o_dw_data_addr_ready;
    logic                             o_dw_resp_valid;
    copperv_bus_pkg::bus_resp_t       dw_resp;
    logic [`COPPERV_ADDR_WIDTH-1:0]   wb_adr;
    logic [`COPPERV_DATA_WIDTH-1:0]   wb_datwr;
    logic [`COPPERV_DATA_WIDTH-1:0]   wb_datrd;
    logic                             wb_we;
    logic                             wb_stb;
    logic                             wb_ack;
    logic                             wb_err;
    logic                             wb_cyc;
    logic [`COPPERV_STROBE_WIDTH-1:0] wb_sel;

    logic [`COPPERV_DATA_WIDTH-1:0]   shadow [c_words];
    int                               checks = 0;
    int                               errors = 0;
    int                               timeouts = 0;
    logic                             watch_we = 1'b0;
    logic                             watch_first = 1'b0;
    int                               we_seen = 0;
    logic                             first_seen = 1'b0;
    logic                             first_we = 1'b0;

    always #2 clock = ~clock;

    wb_copperv_bus i_wb_copperv_bus (
        .i_clock (clock), .i_rst_n (rst_n),
        .i_ir_addr_valid (i_ir_addr_valid), .o_ir_addr_ready (o_ir_addr_ready),
        .i_ir_addr (i_ir_addr), .o_ir_data_valid (o_ir_data_valid),
        .i_ir_data_ready (i_ir_data_ready), .o_ir_data (o_ir_data),
        .i_dr_addr_valid (i_dr_addr_valid), .o_dr_addr_ready (o_dr_addr_ready),
        .i_dr_addr (i_dr_addr), .o_dr_data_valid (o_dr_data_valid),
        .i_dr_data_ready (i_dr_data_ready), .o_dr_data (o_dr_data),
        .i_dw_data_addr_valid (i_dw_data_addr_valid),
        .o_dw_data_addr_ready (o_dw_data_addr_ready),
        .i_dw_data (i_dw_data), .i_dw_addr (i_dw_addr), .i_dw_strobe (i_dw_strobe),
        .o_dw_resp_valid (o_dw_resp_valid), .i_dw_resp_ready (i_dw_resp_ready),
        .o_dw_resp (dw_resp),
        .o_wb_adr (wb_adr), .o_wb_datwr (wb_datwr), .i_wb_datrd (wb_datrd),
        .o_wb_we (wb_we), .o_wb_stb (wb_stb), .i_wb_ack (wb_ack), .i_wb_err (wb_err),
        .o_wb_cyc (wb_cyc), .o_wb_sel (wb_sel)
    );

    wb_memory_model u_memory (
        .i_clock (clock), .i_rst_n (rst_n), .i_wb_adr (wb_adr), .i_wb_datwr (wb_datwr),
        .o_wb_datrd (wb_datrd), .i_wb_we (wb_we), .i_wb_stb (wb_stb), .o_wb_ack (wb_ack),
        .o_wb_err (wb_err), .i_wb_cyc (wb_cyc), .i_wb_sel (wb_sel)
    );

    // bus observations are taken mid-cycle, away from the drive edge.
    always @(negedge clock) begin
        if (wb_cyc && watch_we && wb_we) begin
            we_seen++;
        end
        if (wb_cyc && watch_first && !first_seen) begin
            first_seen = 1'b1;
            first_we   = wb_we;
        end
        if (wb_cyc) begin
            check_flag("wishbone stb during a cycle", wb_stb, 1'b1);
        end
        // reads fetch the whole word.
        if (wb_cyc && !wb_we) begin
            check_flag("all byte lanes selected on a read", &wb_sel, 1'b1);
        end
    end

    function automatic logic [`COPPERV_DATA_WIDTH-1:0] fill_word(input int idx);
        return (idx * 32'h0101_0101) ^ 32'ha5c3_0f96;
    endfunction

    // byte lanes without a strobe keep the old contents.
    function automatic logic [`COPPERV_DATA_WIDTH-1:0] merge_word(
        input logic [`COPPERV_DATA_WIDTH-1:0]   old,
        input logic [`COPPERV_DATA_WIDTH-1:0]   wdata,
        input logic [`COPPERV_STROBE_WIDTH-1:0] strobe
    );
        logic [`COPPERV_DATA_WIDTH-1:0] res;
        res = old;
        for (int b = 0; b < `COPPERV_STROBE_WIDTH; b++) begin
            if (strobe[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic channel_flag(input int sel);
        case (sel)
            c_ir_addr_ready: return o_ir_addr_ready;
            c_ir_data_valid: return o_ir_data_valid;
            c_dr_addr_ready: return o_dr_addr_ready;
            c_dr_data_valid: return o_dr_data_valid;
            c_dw_addr_ready: return o_dw_data_addr_ready;
            default:         return o_dw_resp_valid;
        endcase
    endfunction

    task automatic wait_flag(input int sel, input string what);
        int n;
        n = 0;
        while (!channel_flag(sel) && n < c_timeout) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (!channel_flag(sel)) begin
            timeouts++;
            $display("timeout after %0d cycles waiting for %s", c_timeout, what);
        end
    endtask

    task automatic check_data(input string what, input logic [`COPPERV_DATA_WIDTH-1:0] got,
                              input logic [`COPPERV_DATA_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input string what, input copperv_bus_pkg::bus_resp_t got,
                              input copperv_bus_pkg::bus_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic write_checked(input logic [`COPPERV_ADDR_WIDTH-1:0] addr,
                                 input logic [`COPPERV_DATA_WIDTH-1:0] data,
                                 input logic [`COPPERV_STROBE_WIDTH-1:0] strobe);
        copperv_bus_pkg::bus_resp_t exp;
        exp = addr[31] ? copperv_bus_pkg::RESP_ERR : copperv_bus_pkg::RESP_OK;
        i_dw_addr            = addr;
        i_dw_data            = data;
        i_dw_strobe          = strobe;
        i_dw_data_addr_valid = 1'b1;
        wait_flag(c_dw_addr_ready, "data write address ready");
        @(posedge clock);
        #1;
        i_dw_data_addr_valid = 1'b0;
        wait_flag(c_dw_resp_valid, "data write response valid");
        check_resp("data write response", dw_resp, exp);
        i_dw_resp_ready = 1'b1;
        @(posedge clock);
        #1;
        i_dw_resp_ready = 1'b0;
        if (exp == copperv_bus_pkg::RESP_OK) begin
            shadow[addr[9:2]] = merge_word(shadow[addr[9:2]], data, strobe);
        end
    endtask

    // hold keeps data ready low for that many cycles after data valid.
    task automatic read_checked(input logic [`COPPERV_ADDR_WIDTH-1:0] addr, input int hold);
        i_dr_addr       = addr;
        i_dr_addr_valid = 1'b1;
        wait_flag(c_dr_addr_ready, "data read address ready");
        @(posedge clock);
        #1;
        i_dr_addr_valid = 1'b0;
        wait_flag(c_dr_data_valid, "data read data valid");
        check_data("data read word", o_dr_data, shadow[addr[9:2]]);
        for (int n = 0; n < hold; n++) begin
            check_flag("data valid under back-pressure", o_dr_data_valid, 1'b1);
            check_flag("address ready under back-pressure", o_dr_addr_ready, 1'b0);
            check_data("data under back-pressure", o_dr_data, shadow[addr[9:2]]);
            @(posedge clock);
            #1;
        end
        i_dr_data_ready = 1'b1;
        @(posedge clock);
        #1;
        i_dr_data_ready = 1'b0;
        check_flag("address ready after the data transfer", o_dr_addr_ready, 1'b1);
    endtask

    task automatic instr_checked(input logic [`COPPERV_ADDR_WIDTH-1:0] addr);
        i_ir_addr       = addr;
        i_ir_addr_valid = 1'b1;
        wait_flag(c_ir_addr_ready, "instruction address ready");
        @(posedge clock);
        #1;
        i_ir_addr_valid = 1'b0;
        wait_flag(c_ir_data_valid, "instruction data valid");
        check_data("instruction word", o_ir_data, shadow[addr[9:2]]);
        i_ir_data_ready = 1'b1;
        @(posedge clock);
        #1;
        i_ir_data_ready = 1'b0;
    endtask

    task automatic test_reset();
        check_flag("instruction address ready", o_ir_addr_ready, 1'b1);
        check_flag("data read address ready", o_dr_addr_ready, 1'b1);
        check_flag("data write ready", o_dw_data_addr_ready, 1'b1);
        check_flag("instruction data valid", o_ir_data_valid, 1'b0);
        check_flag("data read data valid", o_dr_data_valid, 1'b0);
        check_flag("data write response valid", o_dw_resp_valid, 1'b0);
        check_flag("wishbone cyc", wb_cyc, 1'b0);
        check_flag("wishbone stb", wb_stb, 1'b0);
        check_flag("wishbone we", wb_we, 1'b0);
    endtask

    task automatic test_write_read();
        write_checked(32'h0000_0040, 32'h1234_5678, 4'b1111);
        read_checked(32'h0000_0040, 0);
        write_checked(32'h0000_0040, 32'hdead_beef, 4'b0101);
        read_checked(32'h0000_0040, 0);
    endtask

    task automatic test_instr_read();
        watch_we = 1'b1;
        instr_checked(32'h0000_0000);
        instr_checked(32'h0000_0004);
        instr_checked(32'h0000_0100);
        instr_checked(32'h0000_03fc);
        watch_we = 1'b0;
        check_flag("write enable seen during instruction reads", we_seen != 0, 1'b0);
    endtask

    task automatic test_read_only();
        write_checked(32'h8000_0020, 32'hffff_0000, 4'b1111);
        read_checked(32'h8000_0020, 0);
    endtask

    task automatic test_contention();
        watch_first = 1'b1;
        fork
            write_checked(32'h0000_0080, 32'h0bad_cafe, 4'b1111);
            read_checked(32'h0000_0084, 0);
            instr_checked(32'h0000_0088);
        join
        watch_first = 1'b0;
        check_flag("first contended cycle seen", first_seen, 1'b1);
        check_flag("write enable of the first contended cycle", first_we, 1'b1);
        read_checked(32'h0000_0080, 0);
    endtask

    initial begin
        rst_n                = 1'b0;
        i_ir_addr_valid      = 1'b0;
        i_ir_addr            = '0;
        i_ir_data_ready      = 1'b0;
        i_dr_addr_valid      = 1'b0;
        i_dr_addr            = '0;
        i_dr_data_ready      = 1'b0;
        i_dw_data_addr_valid = 1'b0;
        i_dw_data            = '0;
        i_dw_addr            = '0;
        i_dw_strobe          = '0;
        i_dw_resp_ready      = 1'b0;
        for (int i = 0; i < c_words; i++) begin
            shadow[i] = fill_word(i);
        end
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_write_read();
        test_instr_read();
        test_read_only();
        test_contention();
        read_checked(32'h0000_00c0, 10);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/wb_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "copperv_bus_defs.svh"

module wb_memory_model (
    input  wire                              i_clock,
    input  wire                              i_rst_n,
    input  wire  [`COPPERV_ADDR_WIDTH-1:0]   i_wb_adr,
    input  wire  [`COPPERV_DATA_WIDTH-1:0]   i_wb_datwr,
    output logic [`COPPERV_DATA_WIDTH-1:0]   o_wb_datrd,
    input  wire                              i_wb_we,
    input  wire                              i_wb_stb,
    output logic                             o_wb_ack,
    output logic                             o_wb_err,
    input  wire                              i_wb_cyc,
    input  wire  [`COPPERV_STROBE_WIDTH-1:0] i_wb_sel
);

    localparam int c_words = 256;

    logic [`COPPERV_DATA_WIDTH-1:0] mem [c_words];
    logic [31:0]                    lcg_q;
    logic [31:0]                    lcg_d;
    logic [1:0]                     delay_q;
    logic [1:0]                     wait_q;
    logic [7:0]                     idx;
    logic                           finish;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        for (int i = 0; i < c_words; i++) begin
            mem[i] = (i * 32'h0101_0101) ^ 32'ha5c3_0f96;
        end
    end

    assign idx    = i_wb_adr[9:2];
    assign lcg_d  = lcg_next(lcg_q);
    // the cycle ends once the drawn number of wait cycles has passed.
    assign finish = i_wb_cyc && i_wb_stb && !o_wb_ack && !o_wb_err && (wait_q == delay_q);

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lcg_q    <= 32'h10d2;
            delay_q  <= 2'd0;
            wait_q   <= 2'd0;
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
        end else begin
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
            if (finish) begin
                // writes with bit 31 set hit the read-only region.
                o_wb_err <= i_wb_we && i_wb_adr[31];
                o_wb_ack <= !(i_wb_we && i_wb_adr[31]);
                wait_q   <= 2'd0;
                lcg_q    <= lcg_d;
                delay_q  <= lcg_d[31:30];
            end else if (i_wb_cyc && i_wb_stb && !o_wb_ack && !o_wb_err) begin
                wait_q <= wait_q + 2'd1;
            end
        end
    end

    always @(posedge i_clock) begin
        if (finish) begin
            o_wb_datrd <= mem[idx];
        end
        if (finish && i_wb_we && !i_wb_adr[31]) begin
            for (int b = 0; b < `COPPERV_STROBE_WIDTH; b++) begin
                if (i_wb_sel[b]) begin
                    mem[idx][8*b +: 8] = i_wb_datwr[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/copperv_bus_pkg.sv
logic/wb_read_adapter.sv
logic/wb_write_adapter.sv
logic/wb_arbiter.sv
logic/wb_copperv_bus.sv
testbench/wb_memory_model.sv
testbench/tb_wb_copperv_bus.sv
